// File: filelist.f
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/control_if.sv
logic/phase_sequencer.sv
logic/instr_decoder.sv
logic/program_counter.sv
logic/register_file.sv
logic/execute_unit.sv
logic/cpu_core.sv
verif/cpu_asserts.sv
verif/cpu_tb.sv

// File: logic/control_if.sv
interface control_if;

	ctrl_pkg::src2_sel_t src2_sel;
	ctrl_pkg::imm_sel_t imm_sel;
	ctrl_pkg::alu_op_t alu_op;
	ctrl_pkg::wb_sel_t wb_sel;
	isa_pkg::reg_addr_t rt;
	isa_pkg::reg_addr_t ra;
	isa_pkg::reg_addr_t rb;
	isa_pkg::shamt_t sv;
	isa_pkg::imm_t imm;
	// already limited to writeback
	logic reg_write;

	modport decoder (
		output src2_sel, imm_sel, alu_op, wb_sel,
		output rt, ra, rb, sv, imm, reg_write
	);

	modport datapath (
		input src2_sel, imm_sel, alu_op, wb_sel,
		input rt, ra, rb, sv, imm, reg_write
	);

endinterface

// File: logic/cpu_core.sv
module cpu_core #(
	parameter int pc_width = 10
) (
	input logic clock,
	input logic reset,
	output logic [pc_width-1:0] instr_addr,
	output logic instr_read,
	input isa_pkg::word_t instr_data,
	output isa_pkg::word_t data_addr,
	output isa_pkg::word_t data_wdata,
	output logic data_read,
	output logic data_write,
	input isa_pkg::word_t data_rdata
);

	ctrl_pkg::phase_t phase;
	ctrl_pkg::pc_sel_t pc_sel;
	isa_pkg::br_off_t branch_offset;
	isa_pkg::jmp_off_t jump_offset;
	logic alu_zero;
	isa_pkg::word_t ra_data;
	isa_pkg::word_t rb_data;
	isa_pkg::word_t rt_data;
	isa_pkg::word_t write_data;

	control_if ctrl_bus ();

	phase_sequencer u_phase (
		.clock (clock),
		.reset (reset),
		.phase (phase)
	);

	instr_decoder #(
		.pc_width (pc_width)
	) u_decoder (
		.clock         (clock),
		.reset         (reset),
		.phase         (phase),
		.instr_data    (instr_data),
		.alu_zero      (alu_zero),
		.ctrl          (ctrl_bus.decoder),
		.pc_sel        (pc_sel),
		.branch_offset (branch_offset),
		.jump_offset   (jump_offset),
		.data_read     (data_read),
		.data_write    (data_write),
		.instr_read    (instr_read)
	);

	program_counter #(
		.pc_width (pc_width)
	) u_pc (
		.clock         (clock),
		.reset         (reset),
		.phase         (phase),
		.pc_sel        (pc_sel),
		.branch_offset (branch_offset),
		.jump_offset   (jump_offset),
		.pc            (instr_addr)
	);

	register_file u_regs (
		.clock      (clock),
		.reset      (reset),
		.ctrl       (ctrl_bus.datapath),
		.write_data (write_data),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.rt_data    (rt_data)
	);

	execute_unit u_exec (
		.clock      (clock),
		.reset      (reset),
		.ctrl       (ctrl_bus.datapath),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.rt_data    (rt_data),
		.data_rdata (data_rdata),
		.alu_zero   (alu_zero),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.write_data (write_data)
	);

endmodule

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

	typedef enum logic [2:0] {
		fetch,
		decode,
		execute,
		memaccess,
		writeback
	} phase_t;

	typedef enum logic [1:0] {
		pc_4,
		pc_branch,
		pc_jump
	} pc_sel_t;

	typedef enum logic [2:0] {
		src2_rb,
		src2_imm,
		src2_lsw,
		src2_lswi,
		src2_none
	} src2_sel_t;

	typedef enum logic [2:0] {
		imm_5_ze,
		imm_15_se,
		imm_15_ze,
		imm_20_se,
		imm_none
	} imm_sel_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_imm,
		wb_load,
		wb_none
	} wb_sel_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_srl,
		alu_sll,
		alu_rotr,
		alu_pass
	} alu_op_t;

endpackage

// File: logic/execute_unit.sv
module execute_unit (
	input logic clock,
	input logic reset,
	control_if.datapath ctrl,
	input isa_pkg::word_t ra_data,
	input isa_pkg::word_t rb_data,
	input isa_pkg::word_t rt_data,
	input isa_pkg::word_t data_rdata,
	output logic alu_zero,
	output isa_pkg::word_t data_addr,
	output isa_pkg::word_t data_wdata,
	output isa_pkg::word_t write_data
);

	isa_pkg::word_t ra_q;
	isa_pkg::word_t rb_q;
	isa_pkg::word_t rt_q;
	isa_pkg::word_t imm_ext;
	isa_pkg::word_t imm15_se;
	isa_pkg::word_t op_a;
	isa_pkg::word_t op_b;
	isa_pkg::word_t alu_res;
	isa_pkg::word_t result_q;
	isa_pkg::word_t load_q;
	logic [63:0] rot;

	// operands stay put from decode until the write in writeback
	always_ff @(posedge clock) begin
		ra_q <= ra_data;
		rb_q <= rb_data;
		rt_q <= rt_data;
		result_q <= alu_res;
		load_q <= data_rdata;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			alu_zero <= 1'b0;
		end else begin
			alu_zero <= (alu_res == '0);
		end
	end

	assign imm15_se = {{17{ctrl.imm[14]}}, ctrl.imm[14:0]};

	always_comb begin
		case (ctrl.imm_sel)
			ctrl_pkg::imm_5_ze: imm_ext = {27'b0, ctrl.imm[14:10]};
			ctrl_pkg::imm_15_se: imm_ext = imm15_se;
			ctrl_pkg::imm_15_ze: imm_ext = {17'b0, ctrl.imm[14:0]};
			ctrl_pkg::imm_20_se: imm_ext = {{12{ctrl.imm[19]}}, ctrl.imm};
			ctrl_pkg::imm_none: imm_ext = '0;
			default: imm_ext = '0;
		endcase
	end

	// branches compare rt against ra
	assign op_a = (ctrl.src2_sel == ctrl_pkg::src2_none) ? rt_q : ra_q;

	always_comb begin
		case (ctrl.src2_sel)
			ctrl_pkg::src2_rb: op_b = rb_q;
			ctrl_pkg::src2_imm: op_b = imm_ext;
			ctrl_pkg::src2_lsw: op_b = rb_q << ctrl.sv;
			ctrl_pkg::src2_lswi: op_b = imm15_se << 2;
			ctrl_pkg::src2_none: op_b = ra_q;
			default: op_b = '0;
		endcase
	end

	assign rot = {op_a, op_a} >> op_b[4:0];

	always_comb begin
		case (ctrl.alu_op)
			ctrl_pkg::alu_add: alu_res = op_a + op_b;
			ctrl_pkg::alu_sub: alu_res = op_a - op_b;
			ctrl_pkg::alu_and: alu_res = op_a & op_b;
			ctrl_pkg::alu_or: alu_res = op_a | op_b;
			ctrl_pkg::alu_xor: alu_res = op_a ^ op_b;
			ctrl_pkg::alu_srl: alu_res = op_a >> op_b[4:0];
			ctrl_pkg::alu_sll: alu_res = op_a << op_b[4:0];
			ctrl_pkg::alu_rotr: alu_res = rot[31:0];
			default: alu_res = op_b;
		endcase
	end

	assign data_addr = result_q;
	assign data_wdata = rt_q;

	always_comb begin
		case (ctrl.wb_sel)
			ctrl_pkg::wb_alu: write_data = result_q;
			ctrl_pkg::wb_imm: write_data = imm_ext;
			ctrl_pkg::wb_load: write_data = load_q;
			ctrl_pkg::wb_none: write_data = '0;
			default: write_data = '0;
		endcase
	end

endmodule

// File: logic/instr_decoder.sv
module instr_decoder #(
	parameter int pc_width = 10
) (
	input logic clock,
	input logic reset,
	input ctrl_pkg::phase_t phase,
	input isa_pkg::word_t instr_data,
	input logic alu_zero,
	control_if.decoder ctrl,
	output ctrl_pkg::pc_sel_t pc_sel,
	output isa_pkg::br_off_t branch_offset,
	output isa_pkg::jmp_off_t jump_offset,
	output logic data_read,
	output logic data_write,
	output logic instr_read
);

	isa_pkg::word_t instr_q;
	isa_pkg::opcode_t opcode;
	isa_pkg::sub_base_t sub_base;
	isa_pkg::sub_ls_t sub_ls;
	logic br_sense;
	logic do_write;
	logic do_read;
	logic do_store;

	if (pc_width < 3 || pc_width > 32) begin : g_pc_width_check
		$error("instr_decoder: pc_width must lie in 3..32");
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instr_q <= '0;
		end else if (phase == ctrl_pkg::fetch) begin
			instr_q <= instr_data;
		end
	end

	assign opcode = instr_q[isa_pkg::op_lsb +: $bits(isa_pkg::opcode_t)];
	assign sub_base = instr_q[isa_pkg::sub_lsb +: $bits(isa_pkg::sub_base_t)];
	assign sub_ls = instr_q[isa_pkg::sub_lsb +: $bits(isa_pkg::sub_ls_t)];
	assign br_sense = instr_q[isa_pkg::br_sense_bit];

	assign ctrl.rt = instr_q[isa_pkg::rt_lsb +: $bits(isa_pkg::reg_addr_t)];
	assign ctrl.ra = instr_q[isa_pkg::ra_lsb +: $bits(isa_pkg::reg_addr_t)];
	assign ctrl.rb = instr_q[isa_pkg::rb_lsb +: $bits(isa_pkg::reg_addr_t)];
	assign ctrl.sv = instr_q[isa_pkg::sv_lsb +: $bits(isa_pkg::shamt_t)];
	assign ctrl.imm = instr_q[isa_pkg::imm_lsb +: $bits(isa_pkg::imm_t)];
	assign branch_offset = instr_q[isa_pkg::imm_lsb +: $bits(isa_pkg::br_off_t)];
	assign jump_offset = instr_q[isa_pkg::imm_lsb +: $bits(isa_pkg::jmp_off_t)];

	// unknown codes fall through to no write and no access
	always_comb begin
		ctrl.src2_sel = ctrl_pkg::src2_none;
		ctrl.imm_sel = ctrl_pkg::imm_none;
		ctrl.alu_op = ctrl_pkg::alu_pass;
		ctrl.wb_sel = ctrl_pkg::wb_none;
		do_write = 1'b0;
		do_read = 1'b0;
		do_store = 1'b0;
		case (opcode)
			isa_pkg::opc_ty_base: begin
				ctrl.src2_sel = ctrl_pkg::src2_rb;
				ctrl.wb_sel = ctrl_pkg::wb_alu;
				do_write = 1'b1;
				case (sub_base)
					isa_pkg::sub_add: ctrl.alu_op = ctrl_pkg::alu_add;
					isa_pkg::sub_sub: ctrl.alu_op = ctrl_pkg::alu_sub;
					isa_pkg::sub_and: ctrl.alu_op = ctrl_pkg::alu_and;
					isa_pkg::sub_xor: ctrl.alu_op = ctrl_pkg::alu_xor;
					isa_pkg::sub_or: ctrl.alu_op = ctrl_pkg::alu_or;
					isa_pkg::sub_slli: ctrl.alu_op = ctrl_pkg::alu_sll;
					isa_pkg::sub_srli: ctrl.alu_op = ctrl_pkg::alu_srl;
					isa_pkg::sub_rotri: ctrl.alu_op = ctrl_pkg::alu_rotr;
					default: begin
						ctrl.wb_sel = ctrl_pkg::wb_none;
						do_write = 1'b0;
					end
				endcase
				// shift amount comes from the immediate
				if (sub_base inside {isa_pkg::sub_slli, isa_pkg::sub_srli, isa_pkg::sub_rotri}) begin
					ctrl.src2_sel = ctrl_pkg::src2_imm;
					ctrl.imm_sel = ctrl_pkg::imm_5_ze;
				end
			end
			isa_pkg::opc_addi, isa_pkg::opc_ori, isa_pkg::opc_xori: begin
				ctrl.src2_sel = ctrl_pkg::src2_imm;
				ctrl.wb_sel = ctrl_pkg::wb_alu;
				do_write = 1'b1;
				if (opcode == isa_pkg::opc_addi) begin
					ctrl.imm_sel = ctrl_pkg::imm_15_se;
					ctrl.alu_op = ctrl_pkg::alu_add;
				end else begin
					ctrl.imm_sel = ctrl_pkg::imm_15_ze;
					ctrl.alu_op = (opcode == isa_pkg::opc_ori) ? ctrl_pkg::alu_or : ctrl_pkg::alu_xor;
				end
			end
			isa_pkg::opc_movi: begin
				ctrl.src2_sel = ctrl_pkg::src2_imm;
				ctrl.imm_sel = ctrl_pkg::imm_20_se;
				ctrl.wb_sel = ctrl_pkg::wb_imm;
				do_write = 1'b1;
			end
			isa_pkg::opc_lwi, isa_pkg::opc_swi: begin
				ctrl.src2_sel = ctrl_pkg::src2_lswi;
				ctrl.alu_op = ctrl_pkg::alu_add;
				do_read = (opcode == isa_pkg::opc_lwi);
				do_store = (opcode == isa_pkg::opc_swi);
			end
			isa_pkg::opc_ty_ls: begin
				ctrl.src2_sel = ctrl_pkg::src2_lsw;
				ctrl.alu_op = ctrl_pkg::alu_add;
				do_read = (sub_ls == isa_pkg::ls_lw);
				do_store = (sub_ls == isa_pkg::ls_sw);
			end
			// compare is rt minus ra
			isa_pkg::opc_ty_b: begin
				ctrl.alu_op = ctrl_pkg::alu_sub;
			end
			default: begin
				ctrl.alu_op = ctrl_pkg::alu_pass;
			end
		endcase
		if (do_read) begin
			ctrl.wb_sel = ctrl_pkg::wb_load;
			do_write = 1'b1;
		end
	end

	always_comb begin
		pc_sel = ctrl_pkg::pc_4;
		if (opcode == isa_pkg::opc_ty_b) begin
			if ((br_sense == isa_pkg::br_beq && alu_zero) ||
					(br_sense == isa_pkg::br_bne && !alu_zero)) begin
				pc_sel = ctrl_pkg::pc_branch;
			end
		end else if (opcode == isa_pkg::opc_jj) begin
			pc_sel = ctrl_pkg::pc_jump;
		end
	end

	assign instr_read = (phase == ctrl_pkg::fetch);
	assign data_read = do_read && (phase == ctrl_pkg::memaccess);
	assign data_write = do_store && (phase == ctrl_pkg::memaccess);
	assign ctrl.reg_write = do_write && (phase == ctrl_pkg::writeback);

endmodule

// File: logic/isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [4:0] sub_base_t;
	typedef logic [7:0] sub_ls_t;
	typedef logic [1:0] shamt_t;
	typedef logic [19:0] imm_t;
	typedef logic [13:0] br_off_t;
	typedef logic [23:0] jmp_off_t;

	// lsb of each instruction field
	localparam int op_lsb = 25;
	localparam int rt_lsb = 20;
	localparam int ra_lsb = 15;
	localparam int rb_lsb = 10;
	localparam int sv_lsb = 8;
	localparam int sub_lsb = 0;
	localparam int imm_lsb = 0;
	localparam int br_sense_bit = 14;

	// major opcodes
	localparam opcode_t opc_ty_base = 6'b100000;
	localparam opcode_t opc_addi = 6'b101000;
	localparam opcode_t opc_ori = 6'b101100;
	localparam opcode_t opc_xori = 6'b101011;
	localparam opcode_t opc_movi = 6'b100010;
	localparam opcode_t opc_lwi = 6'b000010;
	localparam opcode_t opc_swi = 6'b001010;
	localparam opcode_t opc_ty_ls = 6'b011100;
	localparam opcode_t opc_ty_b = 6'b100110;
	localparam opcode_t opc_jj = 6'b100100;

	// base sub-ops
	localparam sub_base_t sub_add = 5'd0;
	localparam sub_base_t sub_sub = 5'd1;
	localparam sub_base_t sub_and = 5'd2;
	localparam sub_base_t sub_xor = 5'd3;
	localparam sub_base_t sub_or = 5'd4;
	localparam sub_base_t sub_slli = 5'd8;
	localparam sub_base_t sub_srli = 5'd9;
	localparam sub_base_t sub_rotri = 5'd11;

	localparam sub_ls_t ls_lw = 8'h02;
	localparam sub_ls_t ls_sw = 8'h0a;

	localparam logic br_beq = 1'b0;
	localparam logic br_bne = 1'b1;

endpackage

// File: logic/phase_sequencer.sv
module phase_sequencer (
	input logic clock,
	input logic reset,
	output ctrl_pkg::phase_t phase
);

	ctrl_pkg::phase_t phase_next;

	always_comb begin
		case (phase)
			ctrl_pkg::fetch: begin
				phase_next = ctrl_pkg::decode;
			end
			ctrl_pkg::decode: begin
				phase_next = ctrl_pkg::execute;
			end
			ctrl_pkg::execute: begin
				phase_next = ctrl_pkg::memaccess;
			end
			ctrl_pkg::memaccess: begin
				phase_next = ctrl_pkg::writeback;
			end
			ctrl_pkg::writeback: begin
				phase_next = ctrl_pkg::fetch;
			end
			// stray encoding, restart the instruction
			default: begin
				phase_next = ctrl_pkg::fetch;
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= ctrl_pkg::fetch;
		end else begin
			phase <= phase_next;
		end
	end

endmodule

// File: logic/program_counter.sv
module program_counter #(
	parameter int pc_width = 10
) (
	input logic clock,
	input logic reset,
	input ctrl_pkg::phase_t phase,
	input ctrl_pkg::pc_sel_t pc_sel,
	input isa_pkg::br_off_t branch_offset,
	input isa_pkg::jmp_off_t jump_offset,
	output logic [pc_width-1:0] pc
);

	isa_pkg::word_t branch_step;
	isa_pkg::word_t jump_step;
	isa_pkg::word_t step;

	// offsets count halfwords
	assign branch_step = {{17{branch_offset[13]}}, branch_offset, 1'b0};
	assign jump_step = {{7{jump_offset[23]}}, jump_offset, 1'b0};

	always_comb begin
		case (pc_sel)
			ctrl_pkg::pc_branch: step = branch_step;
			ctrl_pkg::pc_jump: step = jump_step;
			default: step = 32'd4;
		endcase
	end

	// wraps at pc_width
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (phase == ctrl_pkg::writeback) begin
			pc <= pc + step[pc_width-1:0];
		end
	end

endmodule

// File: logic/register_file.sv
module register_file (
	input logic clock,
	input logic reset,
	control_if.datapath ctrl,
	input isa_pkg::word_t write_data,
	output isa_pkg::word_t ra_data,
	output isa_pkg::word_t rb_data,
	output isa_pkg::word_t rt_data
);

	localparam int num_regs = 2 ** $bits(isa_pkg::reg_addr_t);

	isa_pkg::word_t regs [num_regs];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.reg_write) begin
			regs[ctrl.rt] <= write_data;
		end
	end

	assign ra_data = regs[ctrl.ra];
	assign rb_data = regs[ctrl.rb];
	// store data and branch compare
	assign rt_data = regs[ctrl.rt];

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f filelist.f -o cpu_sim
./obj_dir/cpu_sim

// File: verif/cpu_asserts.sv
module cpu_asserts (
	input logic clock,
	input logic reset,
	input logic instr_read,
	input logic data_read,
	input logic data_write
);

	int fail_count = 0;
	logic [2:0] settle;

	// history of instr_read is complete four cycles out of reset
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			settle <= '0;
		end else if (settle != 3'd4) begin
			settle <= settle + 3'd1;
		end
	end

	strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(data_read && data_write))
	else begin
		fail_count++;
		$error("data_read and data_write are high together");
	end

	read_one_cycle: assert property (@(posedge clock) disable iff (reset)
		data_read |=> !data_read)
	else begin
		fail_count++;
		$error("data_read lasts more than one cycle");
	end

	write_one_cycle: assert property (@(posedge clock) disable iff (reset)
		data_write |=> !data_write)
	else begin
		fail_count++;
		$error("data_write lasts more than one cycle");
	end

	// one fetch in every window of five cycles
	fetch_one_in_five: assert property (@(posedge clock) disable iff (reset)
		(settle == 3'd4) |-> $countones({instr_read, $past(instr_read, 1),
			$past(instr_read, 2), $past(instr_read, 3), $past(instr_read, 4)}) == 1)
	else begin
		fail_count++;
		$error("instr_read is not high exactly one cycle in five");
	end

endmodule

// File: verif/cpu_tb.sv
module cpu_tb;

	localparam int pc_width = 10;
	localparam int mem_words = 256;

	logic clock;
	logic reset;
	logic [pc_width-1:0] instr_addr;
	logic instr_read;
	isa_pkg::word_t instr_data;
	isa_pkg::word_t data_addr;
	isa_pkg::word_t data_wdata;
	logic data_read;
	logic data_write;
	isa_pkg::word_t data_rdata;

	isa_pkg::word_t imem [mem_words];
	isa_pkg::word_t dmem [mem_words];
	isa_pkg::word_t model_mem [mem_words];
	isa_pkg::word_t model_regs [32];
	isa_pkg::word_t prog [$];
	logic [pc_width-1:0] exp_fetch [$];
	isa_pkg::word_t exp_st_addr [$];
	isa_pkg::word_t exp_st_data [$];
	isa_pkg::word_t exp_ld_addr [$];

	cpu_core #(
		.pc_width (pc_width)
	) dut (
		.clock      (clock),
		.reset      (reset),
		.instr_addr (instr_addr),
		.instr_read (instr_read),
		.instr_data (instr_data),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_read  (data_read),
		.data_write (data_write),
		.data_rdata (data_rdata)
	);

	bind cpu_core cpu_asserts u_asserts (
		.clock      (clock),
		.reset      (reset),
		.instr_read (instr_read),
		.data_read  (data_read),
		.data_write (data_write)
	);

	// both memories answer in the same cycle
	assign instr_data = imem[instr_addr[pc_width-1:2]];
	assign data_rdata = dmem[data_addr[9:2]];

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input isa_pkg::word_t got,
			input isa_pkg::word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input logic [pc_width-1:0] got,
			input logic [pc_width-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	function automatic isa_pkg::word_t fill_pattern(input int idx);
		return 32'(idx) * 32'h9e37_79b1 + 32'h1234_5678;
	endfunction

	function automatic isa_pkg::word_t base_instr(input logic [4:0] sub, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, isa_pkg::opc_ty_base, rt, ra, rb, 5'b0, sub};
	endfunction

	function automatic isa_pkg::word_t imm_instr(input isa_pkg::opcode_t op,
			input logic [4:0] rt, input logic [4:0] ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic isa_pkg::word_t movi_instr(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, isa_pkg::opc_movi, rt, imm};
	endfunction

	function automatic isa_pkg::word_t ls_instr(input logic [7:0] sub, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic [1:0] sv);
		return {1'b0, isa_pkg::opc_ty_ls, rt, ra, rb, sv, sub};
	endfunction

	function automatic isa_pkg::word_t branch_instr(input logic bne, input logic [4:0] rt,
			input logic [4:0] ra, input logic [13:0] off);
		return {1'b0, isa_pkg::opc_ty_b, rt, ra, bne, off};
	endfunction

	function automatic isa_pkg::word_t jump_instr(input logic [23:0] off);
		return {1'b0, isa_pkg::opc_jj, 1'b0, off};
	endfunction

	// expected fetches, loads and stores from the instruction rules
	task automatic predict_program();
		logic [pc_width-1:0] pc;
		isa_pkg::word_t w;
		isa_pkg::word_t a;
		isa_pkg::word_t b;
		isa_pkg::word_t addr;
		isa_pkg::word_t step;
		logic [4:0] rt;
		int sh;
		int steps;
		logic done;
		pc = '0;
		steps = 0;
		done = 1'b0;
		foreach (model_regs[i]) model_regs[i] = '0;
		exp_fetch.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		exp_ld_addr.delete();
		while (!done) begin
			if (steps == 500) begin
				abort_run("reference model never reached the final self-jump");
			end
			steps++;
			exp_fetch.push_back(pc);
			w = imem[pc[pc_width-1:2]];
			rt = w[24:20];
			a = model_regs[w[19:15]];
			b = model_regs[w[14:10]];
			sh = int'(w[14:10]);
			step = 32'd4;
			case (w[30:25])
				isa_pkg::opc_ty_base: begin
					case (w[4:0])
						isa_pkg::sub_add: model_regs[rt] = a + b;
						isa_pkg::sub_sub: model_regs[rt] = a - b;
						isa_pkg::sub_and: model_regs[rt] = a & b;
						isa_pkg::sub_xor: model_regs[rt] = a ^ b;
						isa_pkg::sub_or: model_regs[rt] = a | b;
						isa_pkg::sub_slli: model_regs[rt] = a << sh;
						isa_pkg::sub_srli: model_regs[rt] = a >> sh;
						isa_pkg::sub_rotri: model_regs[rt] = (a >> sh) | (a << (32 - sh));
						default: ;
					endcase
				end
				isa_pkg::opc_addi: model_regs[rt] = a + {{17{w[14]}}, w[14:0]};
				isa_pkg::opc_ori: model_regs[rt] = a | {17'b0, w[14:0]};
				isa_pkg::opc_xori: model_regs[rt] = a ^ {17'b0, w[14:0]};
				isa_pkg::opc_movi: model_regs[rt] = {{12{w[19]}}, w[19:0]};
				isa_pkg::opc_lwi, isa_pkg::opc_swi, isa_pkg::opc_ty_ls: begin
					if (w[30:25] == isa_pkg::opc_ty_ls) begin
						addr = a + (b << w[9:8]);
					end else begin
						addr = a + ({{17{w[14]}}, w[14:0]} << 2);
					end
					if (w[30:25] == isa_pkg::opc_lwi ||
							(w[30:25] == isa_pkg::opc_ty_ls && w[7:0] == isa_pkg::ls_lw)) begin
						exp_ld_addr.push_back(addr);
						model_regs[rt] = model_mem[addr[9:2]];
					end else if (w[30:25] == isa_pkg::opc_swi ||
							(w[30:25] == isa_pkg::opc_ty_ls && w[7:0] == isa_pkg::ls_sw)) begin
						exp_st_addr.push_back(addr);
						exp_st_data.push_back(model_regs[rt]);
						model_mem[addr[9:2]] = model_regs[rt];
					end
				end
				isa_pkg::opc_ty_b: begin
					if ((model_regs[rt] == a) != w[14]) begin
						step = {{17{w[13]}}, w[13:0], 1'b0};
					end
				end
				isa_pkg::opc_jj: begin
					step = {{7{w[23]}}, w[23:0], 1'b0};
					done = (w[23:0] == 24'd0);
				end
				default: ;
			endcase
			pc = pc + step[pc_width-1:0];
		end
	endtask

	task automatic run_program();
		int cycle;
		int last_fetch;
		int n_fetch;
		int n_load;
		int n_store;
		int limit;
		@(posedge clock);
		#10;
		reset = 1'b1;
		foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : '0;
		foreach (dmem[i]) begin
			dmem[i] = fill_pattern(i);
			model_mem[i] = dmem[i];
		end
		predict_program();
		repeat (10) begin
			@(negedge clock);
			check_bit("data_read", data_read, 1'b0);
			check_bit("data_write", data_write, 1'b0);
			check_addr("instr_addr", instr_addr, '0);
		end
		@(posedge clock);
		#10;
		reset = 1'b0;
		cycle = 0;
		last_fetch = 0;
		n_fetch = 0;
		n_load = 0;
		n_store = 0;
		limit = 5 * exp_fetch.size() + 20;
		while (n_fetch < exp_fetch.size()) begin
			@(negedge clock);
			cycle++;
			if (cycle > limit) begin
				abort_run("timeout waiting for the fetch of the final self-jump");
			end
			if (data_read && data_write) begin
				abort_run("data_read and data_write are high in the same cycle");
			end
			if (instr_read) begin
				check_addr("instr_addr", instr_addr, exp_fetch[n_fetch]);
				if (n_fetch > 0) begin
					check_count("cycles between fetches", cycle - last_fetch, 5);
				end
				last_fetch = cycle;
				n_fetch++;
			end
			if (data_read) begin
				if (n_load >= exp_ld_addr.size()) begin
					abort_run("data_read is high although no load is expected");
				end
				check_word("data_addr", data_addr, exp_ld_addr[n_load]);
				n_load++;
			end
			if (data_write) begin
				if (n_store >= exp_st_addr.size()) begin
					abort_run("data_write is high although no store is expected");
				end
				// memaccess is the fourth cycle of the instruction
				check_count("cycles from fetch to data_write", cycle - last_fetch, 3);
				check_word("data_addr", data_addr, exp_st_addr[n_store]);
				check_word("data_wdata", data_wdata, exp_st_data[n_store]);
				dmem[data_addr[9:2]] = data_wdata;
				n_store++;
			end
		end
		check_count("loads", n_load, exp_ld_addr.size());
		check_count("stores", n_store, exp_st_addr.size());
	endtask

	// movi, then shift up and or in the low bits
	task automatic emit_constant(input logic [4:0] r, input isa_pkg::word_t v);
		prog.push_back(movi_instr(r, v[31:12]));
		prog.push_back(base_instr(isa_pkg::sub_slli, r, r, 5'd12));
		prog.push_back(imm_instr(isa_pkg::opc_ori, r, r, {3'b0, v[11:0]}));
	endtask

	task automatic store_result(input isa_pkg::word_t instr, input int slot);
		prog.push_back(instr);
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd4, 5'd0, 15'(slot)));
	endtask

	task automatic reset_behavior();
		prog.delete();
		prog.push_back(jump_instr(24'd0));
		run_program();
	endtask

	task automatic arith_ops();
		prog.delete();
		emit_constant(5'd1, $urandom());
		emit_constant(5'd2, $urandom());
		// negative movi
		prog.push_back(movi_instr(5'd3, 20'h80000 | 20'($urandom())));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd3, 5'd0, 15'd0));
		store_result(base_instr(isa_pkg::sub_add, 5'd4, 5'd1, 5'd2), 1);
		store_result(base_instr(isa_pkg::sub_sub, 5'd4, 5'd1, 5'd2), 2);
		store_result(base_instr(isa_pkg::sub_and, 5'd4, 5'd1, 5'd2), 3);
		store_result(base_instr(isa_pkg::sub_xor, 5'd4, 5'd1, 5'd2), 4);
		store_result(base_instr(isa_pkg::sub_or, 5'd4, 5'd1, 5'd2), 5);
		store_result(base_instr(isa_pkg::sub_slli, 5'd4, 5'd1, 5'($urandom_range(31, 1))), 6);
		store_result(base_instr(isa_pkg::sub_srli, 5'd4, 5'd1, 5'($urandom_range(31, 1))), 7);
		store_result(base_instr(isa_pkg::sub_rotri, 5'd4, 5'd2, 5'($urandom_range(31, 1))), 8);
		store_result(imm_instr(isa_pkg::opc_addi, 5'd4, 5'd1, 15'($urandom())), 9);
		store_result(imm_instr(isa_pkg::opc_ori, 5'd4, 5'd1, 15'($urandom())), 10);
		store_result(imm_instr(isa_pkg::opc_xori, 5'd4, 5'd2, 15'($urandom())), 11);
		prog.push_back(jump_instr(24'd0));
		run_program();
	endtask

	task automatic loads_stores();
		prog.delete();
		prog.push_back(movi_instr(5'd6, 20'd512));
		prog.push_back(movi_instr(5'd7, 20'd4));
		prog.push_back(movi_instr(5'd10, 20'd256));
		// lwi with a negative offset, then a positive one
		prog.push_back(imm_instr(isa_pkg::opc_lwi, 5'd5, 5'd6, 15'h7ffd));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd5, 5'd0, 15'd40));
		prog.push_back(imm_instr(isa_pkg::opc_lwi, 5'd5, 5'd0, 15'd20));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd5, 5'd0, 15'd41));
		for (int sv = 0; sv < 4; sv++) begin
			prog.push_back(ls_instr(isa_pkg::ls_lw, 5'd8, 5'd6, 5'd7, 2'(sv)));
			prog.push_back(ls_instr(isa_pkg::ls_sw, 5'd8, 5'd10, 5'd7, 2'(sv)));
		end
		prog.push_back(jump_instr(24'd0));
		run_program();
	endtask

	task automatic control_flow();
		prog.delete();
		prog.push_back(movi_instr(5'd1, 20'd5));
		prog.push_back(movi_instr(5'd2, 20'd5));
		prog.push_back(movi_instr(5'd3, 20'd7));
		prog.push_back(branch_instr(isa_pkg::br_beq, 5'd1, 5'd2, 14'd4));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd3, 5'd0, 15'd0));
		prog.push_back(branch_instr(isa_pkg::br_bne, 5'd1, 5'd2, 14'd4));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd1, 5'd0, 15'd1));
		prog.push_back(branch_instr(isa_pkg::br_beq, 5'd1, 5'd3, 14'd4));
		prog.push_back(branch_instr(isa_pkg::br_bne, 5'd1, 5'd3, 14'd6));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd3, 5'd0, 15'd2));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd3, 5'd0, 15'd3));
		prog.push_back(jump_instr(24'd6));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd1, 5'd0, 15'd4));
		prog.push_back(jump_instr(24'd6));
		// back to the store at 48
		prog.push_back(jump_instr(24'hfffffc));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd3, 5'd0, 15'd5));
		prog.push_back(jump_instr(24'd0));
		run_program();
	endtask

	task automatic undefined_codes();
		prog.delete();
		prog.push_back(movi_instr(5'd1, 20'h00123));
		prog.push_back(movi_instr(5'd2, 20'h00456));
		prog.push_back({1'b0, 6'b111111, 5'd1, 5'd2, 15'h0});
		prog.push_back(base_instr(5'd20, 5'd2, 5'd1, 5'd1));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd1, 5'd0, 15'd0));
		prog.push_back(imm_instr(isa_pkg::opc_swi, 5'd2, 5'd0, 15'd1));
		prog.push_back(jump_instr(24'd0));
		run_program();
	endtask

	initial begin
		void'($urandom(79));
		reset = 1'b1;
		foreach (imem[i]) imem[i] = '0;
		foreach (dmem[i]) dmem[i] = '0;
		reset_behavior();
		arith_ops();
		loads_stores();
		control_flow();
		undefined_codes();
		if (dut.u_asserts.fail_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			abort_run("a bound assertion on the memory strobes failed");
		end
	end

endmodule
